//--- project.f
+incdir+src
src/pcxt_cfg_pkg.sv
src/pcxt_bus_pkg.sv
src/reset_sequencer.sv
src/speed_config.sv
src/cpu_clock_select.sv
src/bios_loader.sv
src/audio_mixer.sv
src/pcxt_glue_top.sv
sim/tb_clock_gen.sv
sim/tb_top.sv

//--- Makefile
# Verilator build and run of the chipset glue testbench
# the run passes only when the log holds the pass line

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
		--top-module tb_top -Mdir obj_dir -o tb_top
	./obj_dir/tb_top | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_top.sv
// testbench for the chipset glue top level
// walks a table of speed, bios download and audio rows after a reset check
// inputs change 1 ns after the rising edge and outputs are sampled there too

`timescale 1ns/1ps
`include "pcxt_cfg.svh"

module tb_top import pcxt_cfg_pkg::*, pcxt_bus_pkg::*; ();

	typedef enum logic [1:0] {kind_speed, kind_bios, kind_audio} test_kind_e;

	// unused fields of a row stay zero
	typedef struct packed {
		test_kind_e   kind;
		cpu_speed_e   speed;
		logic         exp_turbo;
		ioctl_index_t index;
		ioctl_addr_t  addr;
		bus_data_t    data;
		logic         exp_write;
		bios_addr_t   exp_addr;
		logic         exp_flag;
		logic [7:0]   samples;
	} test_row_t;

	logic clk_chipset;
	logic reset;
	cpu_speed_e speed_i;
	machine_model_e model_i;
	logic biu_done_i;
	logic clk_4_77_i;
	logic clk_7_16_i;
	logic clk_14_318_i;
	logic pclk_i;
	logic opl2_clk_i;
	logic download_i;
	ioctl_index_t ioctl_index_i;
	ioctl_addr_t ioctl_addr_i;
	bus_data_t ioctl_data_i;
	logic ioctl_wr_i;
	logic processor_ready_i;
	logic address_direction_i;
	logic sdram_ready_i;
	logic speaker_i;
	logic signed [15:0] opl2_snd_i;
	bus_data_t tandy_snd_i;
	logic clk_cpu_o;
	logic pclk_o;
	logic opl2_ce_o;
	logic turbo_mode_o;
	logic tandy_mode_o;
	logic sys_reset_o;
	logic reset_cpu_o;
	bios_addr_t bios_addr_o;
	bus_data_t bios_data_o;
	logic bios_write_n_o;
	logic bios_request_o;
	logic bios_protect_o;
	logic tandy_bios_flag_o;
	audio_sample_t audio_o;

	string names[$];
	test_row_t rows[$];
	int error_count = 0;
	int check_count = 0;
	int tests_run = 0;

	tb_clock_gen u_clock_gen (
		.clk_chipset_o (clk_chipset),
		.reset_o       (reset)
	);

	pcxt_glue_top uut (.*);

	////////////////////
	// reporting
	////////////////////
	task automatic report_error(input string name, input string msg);
		$display("ERROR %s: %s", name, msg);
		error_count++;
	endtask

	task automatic check_value(input string name, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		check_count++;
		assert (actual === expected) else begin
			$display("FAIL %s: %s expected %0h actual %0h", name, what, expected, actual);
			error_count++;
		end
	endtask

	// one line per finished test
	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("test %-14s ok", name);
		end else begin
			$display("test %-14s %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic add_row(input string name, input test_kind_e kind, input cpu_speed_e speed,
			input logic turbo, input ioctl_index_t index, input ioctl_addr_t addr,
			input bus_data_t data, input logic write, input bios_addr_t exp_addr,
			input logic flag, input logic [7:0] samples);
		test_row_t row;
		row.kind      = kind;
		row.speed     = speed;
		row.exp_turbo = turbo;
		row.index     = index;
		row.addr      = addr;
		row.data      = data;
		row.exp_write = write;
		row.exp_addr  = exp_addr;
		row.exp_flag  = flag;
		row.samples   = samples;
		names.push_back(name);
		rows.push_back(row);
	endtask

	////////////////////
	// expected values
	////////////////////
	// 17 bit sum of opl2 and speaker level and tandy times 512 then shifted right by two
	function automatic audio_sample_t mix_expected(input logic speaker,
			input logic [15:0] opl2, input bus_data_t tandy);
		int opl2_val;
		int spk_val;
		int tandy_val;
		int sum;
		opl2_val  = int'($signed(opl2));
		spk_val   = speaker ? 0 : 16384;
		tandy_val = int'(tandy);
		sum       = opl2_val + spk_val + tandy_val * 512;
		return audio_sample_t'((sum & 32'h1_FFFF) >> 2);
	endfunction

	// selected clock gets the level and the other two get the opposite
	task automatic drive_clocks(input cpu_speed_e speed, input logic level);
		clk_4_77_i   = (speed == speed_4_77) ? level : ~level;
		clk_7_16_i   = (speed == speed_7_16) ? level : ~level;
		clk_14_318_i = (speed == speed_14_318) ? level : ~level;
		pclk_i       = level;
		opl2_clk_i   = level;
	endtask

	////////////////////
	// test bodies
	////////////////////
	task automatic check_reset_release();
		int cycles;
		string name;
		name = "reset_sequence";
		// all controls parked inside reset
		@(posedge clk_chipset);
		#1;
		check_value(name, "reset_cpu_o", 32'(1), 32'(reset_cpu_o));
		check_value(name, "sys_reset_o", 32'(1), 32'(sys_reset_o));
		check_value(name, "bios_write_n_o", 32'(1), 32'(bios_write_n_o));
		check_value(name, "bios_request_o", 32'(0), 32'(bios_request_o));
		check_value(name, "bios_protect_o", 32'(1), 32'(bios_protect_o));
		check_value(name, "clk_cpu_o", 32'(0), 32'(clk_cpu_o));
		check_value(name, "pclk_o", 32'(0), 32'(pclk_o));
		check_value(name, "opl2_ce_o", 32'(0), 32'(opl2_ce_o));
		check_value(name, "turbo_mode_o", 32'(0), 32'(turbo_mode_o));
		// stop on the first edge that sees reset low
		cycles = 0;
		while (reset && cycles < 10) begin
			@(posedge clk_chipset);
			cycles++;
		end
		assert (!reset) else report_error(name, "reset input never went low");
		#1;
		// model follows the input while the cpu is in reset
		check_value(name, "tandy_mode_o follow", 32'(1), 32'(tandy_mode_o));
		model_i = model_pcxt;
		cycles = 1;
		while (sys_reset_o && cycles < 200) begin
			@(posedge clk_chipset);
			#1;
			cycles++;
		end
		check_value(name, "sys_reset_o hold", 32'(`PCXT_RESET_HOLD), 32'(cycles));
		check_value(name, "tandy_mode_o back", 32'(0), 32'(tandy_mode_o));
		cycles = 0;
		while (reset_cpu_o && cycles < 200) begin
			@(posedge clk_chipset);
			#1;
			cycles++;
		end
		check_value(name, "reset_cpu_o hold", 32'(`PCXT_CPU_RESET_HOLD), 32'(cycles));
		// model was pcxt during cpu reset and must hold now
		model_i = model_tandy;
		@(posedge clk_chipset);
		#1;
		check_value(name, "tandy_mode_o", 32'(0), 32'(tandy_mode_o));
	endtask

	task automatic switch_speed(input test_row_t row, input string name);
		int lvl;
		speed_i    = row.speed;
		biu_done_i = 1'b1;
		@(posedge clk_chipset);
		#1;
		biu_done_i = 1'b0;
		check_value(name, "turbo_mode_o", 32'(row.exp_turbo), 32'(turbo_mode_o));
		// level travels through the sync chain
		for (lvl = 1; lvl >= 0; lvl--) begin
			drive_clocks(row.speed, lvl[0]);
			repeat (`PCXT_SYNC_STAGES) @(posedge clk_chipset);
			#1;
			check_value(name, "clk_cpu_o", 32'(lvl[0]), 32'(clk_cpu_o));
			check_value(name, "pclk_o", 32'(lvl[0]), 32'(pclk_o));
			// opl2 enable only on a rising edge and one cycle wide
			check_value(name, "opl2_ce_o", 32'(lvl[0]), 32'(opl2_ce_o));
			@(posedge clk_chipset);
			#1;
			check_value(name, "opl2_ce_o end", 32'(0), 32'(opl2_ce_o));
		end
	endtask

	task automatic write_bios_byte(input test_row_t row, input string name);
		int cycles;
		int low_cycles;
		// cpu off the bus and download on
		download_i          = 1'b1;
		processor_ready_i   = 1'b0;
		address_direction_i = 1'b1;
		cycles = 0;
		while (bios_protect_o && cycles < 20) begin
			@(posedge clk_chipset);
			#1;
			cycles++;
		end
		assert (!bios_protect_o) else report_error(name, "loader never left idle");
		ioctl_index_i = row.index;
		ioctl_addr_i  = row.addr;
		ioctl_data_i  = row.data;
		ioctl_wr_i    = 1'b1;
		@(posedge clk_chipset);
		#1;
		ioctl_wr_i = 1'b0;
		cycles = 0;
		while (bios_write_n_o && cycles < 60) begin
			@(posedge clk_chipset);
			#1;
			cycles++;
		end
		if (!row.exp_write) begin
			assert (bios_write_n_o) else report_error(name, "write pulse for an unmapped image");
		end else begin
			assert (!bios_write_n_o) else report_error(name, "no write pulse within 60 cycles");
			check_value(name, "bios_addr_o", 32'(row.exp_addr), 32'(bios_addr_o));
			check_value(name, "bios_data_o", 32'(row.data), 32'(bios_data_o));
			check_value(name, "tandy_bios_flag_o", 32'(row.exp_flag), 32'(tandy_bios_flag_o));
			check_value(name, "bios_request_o", 32'(1), 32'(bios_request_o));
			low_cycles = 0;
			while (!bios_write_n_o && low_cycles < 100) begin
				low_cycles++;
				@(posedge clk_chipset);
				#1;
			end
			check_value(name, "write pulse width", 32'(`PCXT_BIOS_WRITE_PULSE),
				32'(low_cycles));
		end
		// loader finishes its gap and drops back to idle
		download_i = 1'b0;
		cycles = 0;
		while (!bios_protect_o && cycles < 100) begin
			@(posedge clk_chipset);
			#1;
			cycles++;
		end
		assert (bios_protect_o) else report_error(name, "loader never returned to idle");
	endtask

	task automatic sample_audio(input test_row_t row, input string name);
		int n;
		logic [31:0] word;
		audio_sample_t expected;
		for (n = 0; n < int'(row.samples); n++) begin
			word        = $urandom;
			opl2_snd_i  = word[15:0];
			tandy_snd_i = word[23:16];
			speaker_i   = word[24];
			expected    = mix_expected(word[24], word[15:0], word[23:16]);
			@(posedge clk_chipset);
			#1;
			check_value(name, "audio_o", 32'(expected), 32'(audio_o));
		end
	endtask

	////////////////////
	// main sequence
	////////////////////
	initial begin
		int errors_before;
		speed_i = speed_4_77;
		model_i = model_tandy;
		biu_done_i = 1'b0;
		drive_clocks(speed_4_77, 1'b0);
		download_i = 1'b0;
		ioctl_index_i = '0;
		ioctl_addr_i = '0;
		ioctl_data_i = '0;
		ioctl_wr_i = 1'b0;
		processor_ready_i = 1'b1;
		address_direction_i = 1'b0;
		sdram_ready_i = 1'b1;
		speaker_i = 1'b1;
		opl2_snd_i = '0;
		tandy_snd_i = '0;
		void'($urandom(32'h9c14_d102));

		// name, kind, speed, turbo, index, addr, data, write, address, flag, samples
		add_row("speed_7_16", kind_speed, speed_7_16, 1, 0, 0, 0, 0, 0, 0, 0);
		add_row("speed_14_318", kind_speed, speed_14_318, 1, 0, 0, 0, 0, 0, 0, 0);
		add_row("speed_4_77", kind_speed, speed_4_77, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row("bios_index0", kind_bios, speed_4_77, 0, 0, 25'h1234, 8'hA5, 1, 20'hF1234, 0, 0);
		add_row("bios_index2", kind_bios, speed_4_77, 0, 2, 25'h8001, 8'h3C, 1, 20'hF8001, 1, 0);
		add_row("bios_index3", kind_bios, speed_4_77, 0, 3, 25'h6ABC, 8'h5A, 1, 20'hEEABC, 0, 0);
		add_row("bios_index5", kind_bios, speed_4_77, 0, 5, 25'h0100, 8'h77, 0, 20'hFFFFF, 0, 0);
		add_row("audio_random", kind_audio, speed_4_77, 0, 0, 0, 0, 0, 0, 0, 32);

		errors_before = error_count;
		check_reset_release();
		finish_test("reset_sequence", errors_before);

		foreach (rows[i]) begin
			errors_before = error_count;
			case (rows[i].kind)
				kind_speed: switch_speed(rows[i], names[i]);
				kind_bios:  write_bios_byte(rows[i], names[i]);
				default:    sample_audio(rows[i], names[i]);
			endcase
			finish_test(names[i], errors_before);
		end

		$display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- sim/tb_clock_gen.sv
// clock and reset source for the testbench
// clk_chipset runs at an 8 ns period
// reset is held high over the first two rising edges and drops 1 ns after

`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_chipset_o,
	output logic reset_o
);

	// free running clock, first rising edge at 4 ns
	initial begin
		clk_chipset_o = 1'b0;
		forever #4 clk_chipset_o = ~clk_chipset_o;
	end

	// release off the edge, same as every other input
	initial begin
		reset_o = 1'b1;
		repeat (2) @(posedge clk_chipset_o);
		#1 reset_o = 1'b0;
	end

endmodule

//--- src/pcxt_glue_top.sv
// chipset side glue of a PC/XT class core, all on clk_chipset
// ties together reset release, speed config, cpu clock selection,
// the bios download writer and the sound mixer
// divided clocks and status bits come in as plain ports

`timescale 1ns/1ps

module pcxt_glue_top import pcxt_cfg_pkg::*, pcxt_bus_pkg::*; (
	input  logic               clk_chipset,
	input  logic               reset,
	// configuration
	input  cpu_speed_e         speed_i,
	input  machine_model_e     model_i,
	input  logic               biu_done_i,
	// incoming clock levels
	input  logic               clk_4_77_i,
	input  logic               clk_7_16_i,
	input  logic               clk_14_318_i,
	input  logic               pclk_i,
	input  logic               opl2_clk_i,
	// download port
	input  logic               download_i,
	input  ioctl_index_t       ioctl_index_i,
	input  ioctl_addr_t        ioctl_addr_i,
	input  bus_data_t          ioctl_data_i,
	input  logic               ioctl_wr_i,
	// cpu and memory status
	input  logic               processor_ready_i,
	input  logic               address_direction_i,
	input  logic               sdram_ready_i,
	// sound sources
	input  logic               speaker_i,
	input  logic signed [15:0] opl2_snd_i,
	input  bus_data_t          tandy_snd_i,
	// clocks and strobes out
	output logic               clk_cpu_o,
	output logic               pclk_o,
	output logic               opl2_ce_o,
	output logic               turbo_mode_o,
	output logic               tandy_mode_o,
	output logic               sys_reset_o,
	output logic               reset_cpu_o,
	// bios write port toward the chipset bus
	output bios_addr_t         bios_addr_o,
	output bus_data_t          bios_data_o,
	output logic               bios_write_n_o,
	output logic               bios_request_o,
	output logic               bios_protect_o,
	output logic               tandy_bios_flag_o,
	output audio_sample_t      audio_o
);

	logic       reset_cpu;
	cpu_speed_e speed_sel;
	logic       tandy_mode;

	assign reset_cpu_o  = reset_cpu;
	assign tandy_mode_o = tandy_mode;

	reset_sequencer u_reset_sequencer (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.sys_reset_o (sys_reset_o),
		.reset_cpu_o (reset_cpu)
	);

	speed_config u_speed_config (
		.clk_chipset  (clk_chipset),
		.reset        (reset),
		.reset_cpu_i  (reset_cpu),
		.speed_i      (speed_i),
		.model_i      (model_i),
		.biu_done_i   (biu_done_i),
		.speed_sel_o  (speed_sel),
		.turbo_mode_o (turbo_mode_o),
		.tandy_mode_o (tandy_mode)
	);

	cpu_clock_select u_cpu_clock_select (
		.clk_chipset  (clk_chipset),
		.reset        (reset),
		.speed_sel_i  (speed_sel),
		.clk_4_77_i   (clk_4_77_i),
		.clk_7_16_i   (clk_7_16_i),
		.clk_14_318_i (clk_14_318_i),
		.pclk_i       (pclk_i),
		.opl2_clk_i   (opl2_clk_i),
		.clk_cpu_o    (clk_cpu_o),
		.pclk_o       (pclk_o),
		.opl2_ce_o    (opl2_ce_o)
	);

	bios_loader u_bios_loader (
		.clk_chipset         (clk_chipset),
		.reset               (reset),
		.sdram_ready_i       (sdram_ready_i),
		.download_i          (download_i),
		.ioctl_index_i       (ioctl_index_i),
		.ioctl_addr_i        (ioctl_addr_i),
		.ioctl_data_i        (ioctl_data_i),
		.ioctl_wr_i          (ioctl_wr_i),
		.processor_ready_i   (processor_ready_i),
		.address_direction_i (address_direction_i),
		.tandy_mode_i        (tandy_mode),
		.bios_addr_o         (bios_addr_o),
		.bios_data_o         (bios_data_o),
		.bios_write_n_o      (bios_write_n_o),
		.bios_request_o      (bios_request_o),
		.bios_protect_o      (bios_protect_o),
		.tandy_bios_flag_o   (tandy_bios_flag_o)
	);

	audio_mixer u_audio_mixer (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.speaker_i   (speaker_i),
		.opl2_snd_i  (opl2_snd_i),
		.tandy_snd_i (tandy_snd_i),
		.audio_o     (audio_o)
	);

endmodule

//--- src/audio_mixer.sv
// mono mix of opl2, pc speaker and tandy sound
// opl2 is signed and sign extended, speaker adds a fixed level
// when low, tandy byte is scaled by 512; result has one cycle latency

`timescale 1ns/1ps

module audio_mixer import pcxt_bus_pkg::*; (
	input  logic               clk_chipset,
	input  logic               reset,
	input  logic               speaker_i,
	input  logic signed [15:0] opl2_snd_i,
	input  bus_data_t          tandy_snd_i,
	output audio_sample_t      audio_o
);

	// speaker drive level, bit 14
	localparam logic [16:0] SPEAKER_LEVEL = 17'd16384;

	logic [16:0] opl2_term;
	logic [16:0] speaker_term;
	logic [16:0] tandy_term;
	logic [16:0] sum_d;
	logic [16:0] sum_q;

	assign opl2_term    = {opl2_snd_i[15], opl2_snd_i};
	// speaker line is active low
	assign speaker_term = speaker_i ? 17'd0 : SPEAKER_LEVEL;
	assign tandy_term   = {tandy_snd_i, 9'd0};
	assign sum_d        = opl2_term + speaker_term + tandy_term;

	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			sum_q <= '0;
		end else begin
			sum_q <= sum_d;
		end
	end

	// sum >> 2, top bit of the shifted value is always zero
	assign audio_o = {1'b0, sum_q[16:2]};

endmodule

//--- src/bios_loader.sv
// writes download bytes into the bios window of system memory
// index 0/1 land at F0000 (index 2 too, marked as tandy bios),
// index 3 lands at EC000, other images are ignored
// each byte becomes one memory write low pulse followed by a gap;
// the download side must space strobes by gap plus two cycles

`timescale 1ns/1ps
`include "pcxt_cfg.svh"

module bios_loader import pcxt_bus_pkg::*; (
	input  logic         clk_chipset,
	input  logic         reset,
	input  logic         sdram_ready_i,
	input  logic         download_i,
	input  ioctl_index_t ioctl_index_i,
	input  ioctl_addr_t  ioctl_addr_i,
	input  bus_data_t    ioctl_data_i,
	input  logic         ioctl_wr_i,
	input  logic         processor_ready_i,
	input  logic         address_direction_i,
	input  logic         tandy_mode_i,
	output bios_addr_t   bios_addr_o,
	output bus_data_t    bios_data_o,
	output logic         bios_write_n_o,
	output logic         bios_request_o,
	output logic         bios_protect_o,
	output logic         tandy_bios_flag_o
);

	localparam int CNT_W = `PCXT_BIOS_CNT_W;
	localparam logic [CNT_W-1:0] PULSE_END = CNT_W'(`PCXT_BIOS_WRITE_PULSE);
	localparam logic [CNT_W-1:0] GAP_END   = CNT_W'(`PCXT_BIOS_WRITE_GAP);

	loader_state_e    state_q;
	logic [CNT_W-1:0] wait_cnt_q;
	bios_addr_t       addr_q;
	bus_data_t        data_q;
	logic             write_n_q;
	logic             tandy_write_q;

	logic             low_64k;
	logic             sel_pcxt;
	logic             sel_tandy;
	logic             sel_ext;
	logic             sel_any;
	bios_addr_t       map_addr;

	////////////////////
	// address map
	////////////////////
	// main bios images only in their first 64k
	assign low_64k   = (ioctl_addr_i[24:16] == 9'd0);
	assign sel_pcxt  = (ioctl_index_i < 8'd2) && low_64k;
	assign sel_tandy = (ioctl_index_i == 8'd2) && low_64k;
	// ec00 option rom, 16k window
	assign sel_ext   = (ioctl_index_i == 8'd3);
	assign sel_any   = sel_pcxt | sel_tandy | sel_ext;

	always_comb begin
		if (sel_ext) begin
			map_addr = {6'b111011, ioctl_addr_i[13:0]};
		end else if (sel_pcxt || sel_tandy) begin
			map_addr = {4'hF, ioctl_addr_i[15:0]};
		end else begin
			map_addr = BIOS_IDLE_ADDR;
		end
	end

	////////////////////
	// loader FSM
	////////////////////
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			state_q       <= loader_idle;
			wait_cnt_q    <= '0;
			addr_q        <= BIOS_IDLE_ADDR;
			data_q        <= BUS_IDLE_DATA;
			write_n_q     <= 1'b1;
			tandy_write_q <= 1'b0;
		end else if (!sdram_ready_i) begin
			// memory not up yet, park everything
			state_q       <= loader_idle;
			wait_cnt_q    <= '0;
			addr_q        <= BIOS_IDLE_ADDR;
			data_q        <= BUS_IDLE_DATA;
			write_n_q     <= 1'b1;
			tandy_write_q <= 1'b0;
		end else begin
			case (state_q)
				loader_idle: begin
					wait_cnt_q    <= '0;
					write_n_q     <= 1'b1;
					tandy_write_q <= 1'b0;
					// wait until the cpu has let go of the bus
					if (download_i && !processor_ready_i && address_direction_i) begin
						state_q <= loader_armed;
					end
				end
				loader_armed: begin
					wait_cnt_q <= '0;
					if (!download_i) begin
						state_q <= loader_idle;
					end else if (ioctl_wr_i && sel_any) begin
						addr_q        <= map_addr;
						data_q        <= ioctl_data_i;
						tandy_write_q <= sel_tandy;
						state_q       <= loader_write;
					end
				end
				loader_write: begin
					wait_cnt_q <= wait_cnt_q + CNT_W'(1);
					// low from count 0 up to PULSE_END
					if (wait_cnt_q == PULSE_END) begin
						write_n_q <= 1'b1;
						state_q   <= loader_gap;
					end else begin
						write_n_q <= 1'b0;
					end
				end
				loader_gap: begin
					wait_cnt_q    <= wait_cnt_q + CNT_W'(1);
					addr_q        <= BIOS_IDLE_ADDR;
					data_q        <= BUS_IDLE_DATA;
					tandy_write_q <= 1'b0;
					if (wait_cnt_q == GAP_END) begin
						state_q <= loader_armed;
					end
				end
				default: state_q <= loader_idle;
			endcase
		end
	end

	assign bios_addr_o       = addr_q;
	assign bios_data_o       = data_q;
	assign bios_write_n_o    = write_n_q;
	assign bios_protect_o    = (state_q == loader_idle);
	// hold the bus from the first download request on
	assign bios_request_o    = (state_q != loader_idle) || download_i;
	assign tandy_bios_flag_o = write_n_q ? tandy_mode_i : tandy_write_q;

	////////////////////
	// checks
	////////////////////
	// a write can only come from the armed state, never from idle
	a_no_write_in_idle: assert property (
		@(posedge clk_chipset) disable iff (reset)
		(state_q == loader_idle) |-> bios_write_n_o
	) else $error("bios_loader: write pulse while idle");

	// pulse ends exactly PCXT_BIOS_WRITE_PULSE cycles after it starts
	a_pulse_width: assert property (
		@(posedge clk_chipset) disable iff (reset)
		$fell(bios_write_n_o) |-> ##(`PCXT_BIOS_WRITE_PULSE) bios_write_n_o
	) else $error("bios_loader: write pulse too long");

endmodule

//--- src/cpu_clock_select.sv
// cpu clock mux plus resynchronizers onto clk_chipset
// the chosen cpu clock level, the peripheral clock and the opl2 clock
// each run through their own flop chain of PCXT_SYNC_STAGES
// opl2 rising edges become a one cycle clock enable

`timescale 1ns/1ps
`include "pcxt_cfg.svh"

module cpu_clock_select import pcxt_cfg_pkg::*; (
	input  logic       clk_chipset,
	input  logic       reset,
	input  cpu_speed_e speed_sel_i,
	input  logic       clk_4_77_i,
	input  logic       clk_7_16_i,
	input  logic       clk_14_318_i,
	input  logic       pclk_i,
	input  logic       opl2_clk_i,
	output logic       clk_cpu_o,
	output logic       pclk_o,
	output logic       opl2_ce_o
);

	localparam int STAGES    = `PCXT_SYNC_STAGES;
	// bit positions inside each chain stage
	localparam int LANE_CPU  = 0;
	localparam int LANE_PCLK = 1;
	localparam int LANE_OPL2 = 2;

	logic                   cpu_level;
	logic [2:0]             lane_in;
	logic [STAGES-1:0][2:0] sync_q;
	logic                   opl2_ce_q;

	// reserved code falls back to the slow clock
	always_comb begin
		case (speed_sel_i)
			speed_14_318: cpu_level = clk_14_318_i;
			speed_7_16:   cpu_level = clk_7_16_i;
			default:      cpu_level = clk_4_77_i;
		endcase
	end

	assign lane_in = {opl2_clk_i, pclk_i, cpu_level};

	// stage 0 samples the async levels, last stage drives out
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			sync_q    <= '0;
			opl2_ce_q <= 1'b0;
		end else begin
			sync_q    <= {sync_q[STAGES-2:0], lane_in};
			// rising edge seen between the last two stages
			opl2_ce_q <= sync_q[STAGES-2][LANE_OPL2] & ~sync_q[STAGES-1][LANE_OPL2];
		end
	end

	assign clk_cpu_o = sync_q[STAGES-1][LANE_CPU];
	assign pclk_o    = sync_q[STAGES-1][LANE_PCLK];
	assign opl2_ce_o = opl2_ce_q;

endmodule

//--- src/speed_config.sv
// speed and model registers next to the cpu clock selector
// speed code is taken only when the bus interface reports a finished
// cycle, so the cpu clock never switches mid cycle
// machine model is latched while the cpu is held in reset

`timescale 1ns/1ps

module speed_config import pcxt_cfg_pkg::*; (
	input  logic           clk_chipset,
	input  logic           reset,
	input  logic           reset_cpu_i,
	input  cpu_speed_e     speed_i,
	input  machine_model_e model_i,
	input  logic           biu_done_i,
	output cpu_speed_e     speed_sel_o,
	output logic           turbo_mode_o,
	output logic           tandy_mode_o
);

	machine_model_e model_q;

	// new speed lands on the cycle after biu done
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			speed_sel_o  <= speed_4_77;
			turbo_mode_o <= 1'b0;
		end else if (biu_done_i) begin
			speed_sel_o  <= speed_i;
			turbo_mode_o <= speed_is_turbo(speed_i);
		end
	end

	// model follows the input only while cpu is in reset
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			model_q <= model_pcxt;
		end else if (reset_cpu_i) begin
			model_q <= model_i;
		end
	end

	assign tandy_mode_o = (model_q == model_tandy);

	////////////////////
	// checks
	////////////////////
	// code 3 has no clock behind it in the selector
	a_speed_code_valid: assert property (
		@(posedge clk_chipset) disable iff (reset)
		speed_sel_o != 2'b11
	) else $error("speed_config: reserved speed code 3 latched");

endmodule

//--- src/reset_sequencer.sv
// two step reset release
// system reset is stretched PCXT_RESET_HOLD cycles past the reset input,
// then the cpu reset waits a further PCXT_CPU_RESET_HOLD cycles
// so the chipset is settled before the first bus cycle

`timescale 1ns/1ps
`include "pcxt_cfg.svh"

module reset_sequencer (
	input  logic clk_chipset,
	input  logic reset,
	output logic sys_reset_o,
	output logic reset_cpu_o
);

	localparam int CNT_W = `PCXT_RESET_CNT_W;
	// last count before each release
	localparam logic [CNT_W-1:0] SYS_LAST = CNT_W'(`PCXT_RESET_HOLD - 1);
	localparam logic [CNT_W-1:0] CPU_LAST = CNT_W'(`PCXT_CPU_RESET_HOLD - 1);

	logic [CNT_W-1:0] sys_cnt_q;
	logic [CNT_W-1:0] cpu_cnt_q;

	////////////////////
	// system reset
	////////////////////
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			sys_reset_o <= 1'b1;
			sys_cnt_q   <= '0;
		end else if (sys_reset_o) begin
			if (sys_cnt_q == SYS_LAST) begin
				sys_reset_o <= 1'b0;
			end else begin
				sys_cnt_q <= sys_cnt_q + CNT_W'(1);
			end
		end
	end

	////////////////////
	// cpu reset
	////////////////////
	// counting starts once system reset is gone
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			reset_cpu_o <= 1'b1;
			cpu_cnt_q   <= '0;
		end else if (sys_reset_o) begin
			cpu_cnt_q <= '0;
		end else if (reset_cpu_o) begin
			if (cpu_cnt_q == CPU_LAST) begin
				reset_cpu_o <= 1'b0;
			end else begin
				cpu_cnt_q <= cpu_cnt_q + CNT_W'(1);
			end
		end
	end

endmodule

//--- src/pcxt_bus_pkg.sv
// bus and loader types for the chipset glue
// memory side address and data, download side address and index,
// loader FSM states and the mixed audio sample
// import into the loader, the mixer and the top level

package pcxt_bus_pkg;

	// 8088 memory address, 1 MB space
	typedef logic [19:0] bios_addr_t;
	// byte on the system bus
	typedef logic [7:0] bus_data_t;
	// byte offset inside a download image
	typedef logic [24:0] ioctl_addr_t;
	// which image the download carries
	typedef logic [7:0] ioctl_index_t;

	// loader FSM
	typedef enum logic [1:0] {
		loader_idle  = 2'd0,
		loader_armed = 2'd1,
		loader_write = 2'd2,
		loader_gap   = 2'd3
	} loader_state_e;

	// mixed output sample
	typedef logic [15:0] audio_sample_t;

	// values parked on the bus while no write is running
	localparam bios_addr_t BIOS_IDLE_ADDR = 20'hFFFFF;
	localparam bus_data_t  BUS_IDLE_DATA  = 8'hFF;

endpackage

//--- src/pcxt_cfg_pkg.sv
// machine configuration types for the chipset glue
// covers the cpu speed code and the machine model
// import into the clock and config blocks and the top level

package pcxt_cfg_pkg;

	// cpu clock choice, code 3 is reserved
	typedef enum logic [1:0] {
		speed_4_77   = 2'd0,
		speed_7_16   = 2'd1,
		speed_14_318 = 2'd2
	} cpu_speed_e;

	// board personality, picks bios flavour and video
	typedef enum logic {
		model_pcxt  = 1'b0,
		model_tandy = 1'b1
	} machine_model_e;

	// anything above 4.77 counts as turbo
	function automatic logic speed_is_turbo(cpu_speed_e speed);
		return (speed == speed_7_16) || (speed == speed_14_318);
	endfunction

endpackage

//--- src/pcxt_cfg.svh
// counts and widths for the chipset glue
// include in any module that needs a hold count or a counter width
// values here are short for simulation; hardware used much longer holds

`ifndef PCXT_CFG_SVH
`define PCXT_CFG_SVH

////////////////////
// reset stretching
////////////////////
// system reset hold after reset input falls
`define PCXT_RESET_HOLD 64
// extra hold before cpu leaves reset
`define PCXT_CPU_RESET_HOLD 42
// width of both reset counters
`define PCXT_RESET_CNT_W 8

////////////////////
// bios loader timing
////////////////////
// memory write low time in clk_chipset cycles
`define PCXT_BIOS_WRITE_PULSE 20
// cycles from write start until loader takes the next byte
`define PCXT_BIOS_WRITE_GAP 40
// must hold PCXT_BIOS_WRITE_GAP
`define PCXT_BIOS_CNT_W 6

// flops per resynchronizer chain
`define PCXT_SYNC_STAGES 3

`endif
